/* include/drum_macros.svh */
`ifndef DRUM_MACROS_SVH
`define DRUM_MACROS_SVH

// Node sample format in signed 1.17
`define DRUM_WIDTH 18
`define DRUM_FRAC 17

// Grid size and row memory depth
`define DRUM_ROW_W 9
`define DRUM_MAX_ROWS 512
`define DRUM_COLS 8
`define DRUM_TAP_COL (`DRUM_COLS / 2)

// Tension in 1.17 with base 0.25 and a limit just under 0.49
`define DRUM_RHO_0 18'sh08000
`define DRUM_RHO_MAX 18'sh0FAE1

// Damping as a right shift
`define DRUM_DAMP_SHIFT 9

`endif

/* design/drum_pkg.sv */
`include "drum_macros.svh"

package drum_pkg;

	// Signed 1.17 node value
	typedef logic signed [`DRUM_WIDTH-1:0] sample_t;

	typedef logic [`DRUM_ROW_W-1:0] row_t;

	// Sequencer phases shared by every column
	typedef enum logic [2:0] {
		ST_LOAD,
		ST_INIT,
		ST_READ,
		ST_WAIT,
		ST_FETCH,
		ST_UPDATE,
		ST_HOLD
	} drum_state_t;

	// 1.17 times 1.17 scaled back to 1.17
	function automatic sample_t fx_mult(input sample_t a, input sample_t b);
		logic signed [2*`DRUM_WIDTH-1:0] prod;
		prod = a * b;
		return {prod[2*`DRUM_WIDTH-1], prod[2*`DRUM_WIDTH-3:`DRUM_FRAC]};
	endfunction

endpackage

/* design/column_ram.sv */
`timescale 1ns/1ps
`include "drum_macros.svh"

module column_ram (
	input  logic              CLOCK_50,
	input  logic              we_i,
	input  drum_pkg::row_t    waddr_i,
	input  drum_pkg::row_t    raddr_i,
	input  drum_pkg::sample_t wdata_i,
	output drum_pkg::sample_t rdata_o
);
	import drum_pkg::*;

	sample_t mem [`DRUM_MAX_ROWS];

	// Read returns the old word on a same-address write
	always_ff @(posedge CLOCK_50) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
		rdata_o <= mem[raddr_i];
	end

endmodule

/* design/node_update.sv */
`timescale 1ns/1ps
`include "drum_macros.svh"

module node_update (
	input  drum_pkg::sample_t u_i,
	input  drum_pkg::sample_t u_left_i,
	input  drum_pkg::sample_t u_right_i,
	input  drum_pkg::sample_t u_up_i,
	input  drum_pkg::sample_t u_down_i,
	input  drum_pkg::sample_t u_prev_i,
	input  drum_pkg::sample_t rho_i,
	output drum_pkg::sample_t u_next_o
);
	import drum_pkg::*;

	sample_t lap_sum;
	sample_t lap_rho;
	sample_t undamped;

	// Discrete Laplacian of the node
	assign lap_sum = u_left_i + u_right_i + u_up_i + u_down_i - (u_i <<< 2);
	assign lap_rho = fx_mult(lap_sum, rho_i);

	// Leapfrog step with a small pull towards the previous value
	assign undamped = lap_rho + (u_i <<< 1) - u_prev_i + (u_prev_i >>> `DRUM_DAMP_SHIFT);

	// Scale by 1 - 2^-9
	assign u_next_o = undamped - (undamped >>> `DRUM_DAMP_SHIFT);

endmodule

/* design/drum_column.sv */
`timescale 1ns/1ps
`include "drum_macros.svh"

module drum_column #(
	parameter int COL_IDX = 0
) (
	input  logic                  CLOCK_50,
	input  logic                  arst_n_i,
	input  drum_pkg::drum_state_t state_i,
	input  drum_pkg::row_t        row_i,
	input  logic                  last_row_i,
	input  drum_pkg::row_t        rows_i,
	input  drum_pkg::sample_t     incr_i,
	input  drum_pkg::sample_t     rho_i,
	input  drum_pkg::sample_t     u_row_i [`DRUM_COLS],
	output drum_pkg::sample_t     u_cur_o
);
	import drum_pkg::*;

	// Distance of this column to the nearer side edge
	localparam int EDGE_DIST = (COL_IDX < `DRUM_COLS - 1 - COL_IDX) ?
		COL_IDX : `DRUM_COLS - 1 - COL_IDX;

	row_t    rows_q;
	sample_t incr_q;
	row_t    row_to_top;
	row_t    row_dist;
	row_t    pyr_lvl;
	sample_t pyr_val;
	sample_t u_up;
	sample_t u_cur;
	sample_t u_down;
	sample_t u_prev;
	sample_t u_bottom;
	sample_t u_left;
	sample_t u_right;
	sample_t u_up_m;
	sample_t u_down_m;
	sample_t u_next;
	logic    mem_we;
	sample_t cur_wdata;
	sample_t prev_wdata;
	sample_t cur_rdata;
	sample_t prev_rdata;

	////////////////////////////////////////
	// Initial pyramid
	////////////////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rows_q <= '0;
			incr_q <= '0;
		end else if (state_i == ST_LOAD) begin
			rows_q <= rows_i;
			incr_q <= incr_i;
		end
	end

	assign row_to_top = rows_q - row_t'(1) - row_i;
	assign row_dist   = (row_i < row_to_top) ? row_i : row_to_top;
	assign pyr_lvl    = ((row_t'(EDGE_DIST) < row_dist) ? row_t'(EDGE_DIST) : row_dist) + row_t'(1);
	assign pyr_val    = sample_t'(pyr_lvl) * incr_q;

	////////////////////////////////////////
	// Neighbours and node update
	////////////////////////////////////////

	// Grid border is clamped to zero
	if (COL_IDX == 0) begin : g_no_left
		assign u_left = '0;
	end else begin : g_left
		assign u_left = u_row_i[COL_IDX-1];
	end

	if (COL_IDX == `DRUM_COLS - 1) begin : g_no_right
		assign u_right = '0;
	end else begin : g_right
		assign u_right = u_row_i[COL_IDX+1];
	end

	assign u_up_m   = last_row_i ? '0 : u_up;
	assign u_down_m = (row_i == '0) ? '0 : u_down;

	node_update u_node (
		.u_i       (u_cur),
		.u_left_i  (u_left),
		.u_right_i (u_right),
		.u_up_i    (u_up_m),
		.u_down_i  (u_down_m),
		.u_prev_i  (u_prev),
		.rho_i     (rho_i),
		.u_next_o  (u_next)
	);

	// Init fills both memories and the sweep writes new and old values back
	assign mem_we     = (state_i == ST_INIT) || (state_i == ST_UPDATE);
	assign cur_wdata  = (state_i == ST_INIT) ? pyr_val : u_next;
	assign prev_wdata = (state_i == ST_INIT) ? pyr_val : u_cur;

	column_ram u_cur_ram (
		.CLOCK_50 (CLOCK_50),
		.we_i     (mem_we),
		.waddr_i  (row_i),
		.raddr_i  (row_i + row_t'(1)),
		.wdata_i  (cur_wdata),
		.rdata_o  (cur_rdata)
	);

	column_ram u_prev_ram (
		.CLOCK_50 (CLOCK_50),
		.we_i     (mem_we),
		.waddr_i  (row_i),
		.raddr_i  (row_i),
		.wdata_i  (prev_wdata),
		.rdata_o  (prev_rdata)
	);

	// Row window moves up one row per update
	always_ff @(posedge CLOCK_50) begin
		case (state_i)
			ST_INIT: begin
				if (row_i == '0) begin
					u_cur <= pyr_val;
				end
			end
			ST_FETCH: begin
				u_up   <= cur_rdata;
				u_prev <= prev_rdata;
			end
			ST_UPDATE: begin
				u_down <= u_cur;
				if (row_i == '0) begin
					u_bottom <= u_next;
				end
				// Wrap back to the freshly computed bottom row
				if (last_row_i) begin
					u_cur <= (row_i == '0) ? u_next : u_bottom;
				end else begin
					u_cur <= u_up;
				end
			end
			default: begin
			end
		endcase
	end

	assign u_cur_o = u_cur;

endmodule

/* design/drum_sequencer.sv */
`timescale 1ns/1ps

module drum_sequencer (
	input  logic                  CLOCK_50,
	input  logic                  arst_n_i,
	input  logic                  run_i,
	input  drum_pkg::row_t        rows_i,
	input  logic                  audio_ack_i,
	input  logic                  sample_valid_i,
	output drum_pkg::drum_state_t state_o,
	output drum_pkg::row_t        row_o,
	output logic                  last_row_o,
	output logic                  tap_o,
	output logic                  step_start_o,
	output logic                  step_end_o
);
	import drum_pkg::*;

	drum_state_t state_q;
	row_t        row_q;
	row_t        rows_q;
	logic        init_done;
	logic        ack_take;

	// Row decisions for the whole grid
	assign init_done  = (row_q == rows_q);
	assign last_row_o = (row_q == rows_q - row_t'(1));
	assign tap_o      = (state_q == ST_UPDATE) && (row_q == (rows_q >> 1));
	assign ack_take   = sample_valid_i && audio_ack_i;

	// Timer marks around each time step
	assign step_start_o = ((state_q == ST_INIT) && init_done) ||
		((state_q == ST_HOLD) && ack_take);
	assign step_end_o   = (state_q == ST_UPDATE) && last_row_o;

	////////////////////////////////////////
	// Phase register and row counter
	////////////////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ST_LOAD;
			row_q   <= '0;
			rows_q  <= '0;
		end else if (!run_i) begin
			state_q <= ST_LOAD;
			row_q   <= '0;
		end else begin
			case (state_q)
				ST_LOAD: begin
					rows_q  <= rows_i;
					row_q   <= '0;
					state_q <= ST_INIT;
				end
				ST_INIT: begin
					if (init_done) begin
						row_q   <= '0;
						state_q <= ST_READ;
					end else begin
						row_q <= row_q + row_t'(1);
					end
				end
				ST_READ:  state_q <= ST_WAIT;
				ST_WAIT:  state_q <= ST_FETCH;
				ST_FETCH: state_q <= ST_UPDATE;
				ST_UPDATE: begin
					if (last_row_o) begin
						row_q   <= '0;
						state_q <= ST_HOLD;
					end else begin
						row_q   <= row_q + row_t'(1);
						state_q <= ST_READ;
					end
				end
				// Sample held until the host takes it
				ST_HOLD: begin
					if (ack_take) begin
						state_q <= ST_READ;
					end
				end
				default: state_q <= ST_LOAD;
			endcase
		end
	end

	assign state_o = state_q;
	assign row_o   = row_q;

endmodule

/* design/step_timer.sv */
`timescale 1ns/1ps

module step_timer (
	input  logic        CLOCK_50,
	input  logic        arst_n_i,
	input  logic        step_start_i,
	input  logic        step_end_i,
	output logic [31:0] step_cycles_o
);

	logic [31:0] cnt_q;
	logic [31:0] cnt_next;

	// Count includes the cycle that ends the step
	assign cnt_next = cnt_q + 32'd1;

	always_ff @(posedge CLOCK_50 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q         <= '0;
			step_cycles_o <= '0;
		end else begin
			cnt_q <= step_start_i ? '0 : cnt_next;
			if (step_end_i) begin
				step_cycles_o <= cnt_next;
			end
		end
	end

endmodule

/* design/tension_update.sv */
`timescale 1ns/1ps
`include "drum_macros.svh"

module tension_update (
	input  logic                  CLOCK_50,
	input  logic                  arst_n_i,
	input  logic                  tap_i,
	input  drum_pkg::sample_t     tap_value_i,
	input  logic [3:0]            rho_shift_i,
	input  drum_pkg::drum_state_t state_i,
	input  logic                  audio_ack_i,
	output drum_pkg::sample_t     rho_o,
	output drum_pkg::sample_t     sample_o,
	output logic                  sample_valid_o
);
	import drum_pkg::*;

	sample_t               tap_q;
	logic [3:0]            shift_q;
	sample_t               rho_q;
	sample_t               tap_shifted;
	sample_t               tap_sq;
	logic [`DRUM_WIDTH:0]  rho_sum;
	sample_t               rho_next;

	// Tension grows with the square of the centre displacement
	assign tap_shifted = tap_q >>> shift_q;
	assign tap_sq      = fx_mult(tap_shifted, tap_shifted);
	assign rho_sum     = {1'b0, `DRUM_RHO_0} + {1'b0, tap_sq};
	assign rho_next    = (rho_sum < {1'b0, `DRUM_RHO_MAX}) ?
		rho_sum[`DRUM_WIDTH-1:0] : `DRUM_RHO_MAX;

	always_ff @(posedge CLOCK_50 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tap_q   <= '0;
			shift_q <= '0;
			rho_q   <= `DRUM_RHO_0;
		end else begin
			if (state_i == ST_LOAD) begin
				shift_q <= rho_shift_i;
				rho_q   <= `DRUM_RHO_0;
			end
			if (tap_i) begin
				tap_q <= tap_value_i;
			end
			// New tension applies from the next step on
			if ((state_i == ST_HOLD) && audio_ack_i) begin
				rho_q <= rho_next;
			end
		end
	end

	assign rho_o          = rho_q;
	assign sample_o       = tap_q;
	assign sample_valid_o = (state_i == ST_HOLD);

endmodule

/* design/drum_synth_top.sv */
`timescale 1ns/1ps
`include "drum_macros.svh"

module drum_synth_top (
	input  logic              CLOCK_50,
	input  logic              arst_n_i,
	input  logic              run_i,
	input  drum_pkg::row_t    rows_i,
	input  drum_pkg::sample_t incr_i,
	input  logic [3:0]        rho_shift_i,
	input  logic              audio_ack_i,
	output drum_pkg::sample_t sample_o,
	output logic              sample_valid_o,
	output logic [31:0]       step_cycles_o
);
	import drum_pkg::*;

	drum_state_t state;
	row_t        row;
	logic        last_row;
	logic        tap;
	logic        step_start;
	logic        step_end;
	sample_t     rho;
	sample_t     u_row [`DRUM_COLS];

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	drum_sequencer u_sequencer (
		.CLOCK_50       (CLOCK_50),
		.arst_n_i       (arst_n_i),
		.run_i          (run_i),
		.rows_i         (rows_i),
		.audio_ack_i    (audio_ack_i),
		.sample_valid_i (sample_valid_o),
		.state_o        (state),
		.row_o          (row),
		.last_row_o     (last_row),
		.tap_o          (tap),
		.step_start_o   (step_start),
		.step_end_o     (step_end)
	);

	step_timer u_timer (
		.CLOCK_50      (CLOCK_50),
		.arst_n_i      (arst_n_i),
		.step_start_i  (step_start),
		.step_end_i    (step_end),
		.step_cycles_o (step_cycles_o)
	);

	// Centre column feeds the output and the tension
	tension_update u_tension (
		.CLOCK_50       (CLOCK_50),
		.arst_n_i       (arst_n_i),
		.tap_i          (tap),
		.tap_value_i    (u_row[`DRUM_TAP_COL]),
		.rho_shift_i    (rho_shift_i),
		.state_i        (state),
		.audio_ack_i    (audio_ack_i),
		.rho_o          (rho),
		.sample_o       (sample_o),
		.sample_valid_o (sample_valid_o)
	);

	////////////////////////////////////////
	// Grid columns
	////////////////////////////////////////

	for (genvar c = 0; c < `DRUM_COLS; c++) begin : g_col
		drum_column #(
			.COL_IDX (c)
		) u_column (
			.CLOCK_50   (CLOCK_50),
			.arst_n_i   (arst_n_i),
			.state_i    (state),
			.row_i      (row),
			.last_row_i (last_row),
			.rows_i     (rows_i),
			.incr_i     (incr_i),
			.rho_i      (rho),
			.u_row_i    (u_row),
			.u_cur_o    (u_row[c])
		);
	end

endmodule

/* bench/drum_synth_asserts.sv */
`timescale 1ns/1ps

module drum_synth_asserts (
	input logic              CLOCK_50,
	input logic              arst_n_i,
	input logic              audio_ack_i,
	input drum_pkg::sample_t sample_i,
	input logic              sample_valid_i
);

	// No sample offered during reset
	valid_low_in_reset: assert property (
		@(posedge CLOCK_50) !arst_n_i |-> !sample_valid_i
	) else $error("sample_valid_o high during reset");

	// Held sample stays put until the host takes it
	sample_stable_held: assert property (
		@(posedge CLOCK_50) disable iff (!arst_n_i)
		(sample_valid_i && !audio_ack_i) |=> (!sample_valid_i || $stable(sample_i))
	) else $error("sample_o changed while held");

	valid_drops_on_ack: assert property (
		@(posedge CLOCK_50) disable iff (!arst_n_i)
		(sample_valid_i && audio_ack_i) |=> !sample_valid_i
	) else $error("sample_valid_o still high after audio_ack_i");

endmodule

bind drum_synth_top drum_synth_asserts u_asserts (
	.CLOCK_50       (CLOCK_50),
	.arst_n_i       (arst_n_i),
	.audio_ack_i    (audio_ack_i),
	.sample_i       (sample_o),
	.sample_valid_i (sample_valid_o)
);

/* bench/drum_synth_tb.sv */
`timescale 1ns/1ps
`include "drum_macros.svh"

module drum_synth_tb;

	localparam int MAX_CASES  = 8;
	localparam int WAIT_LIMIT = 20000;

	typedef logic signed [`DRUM_WIDTH-1:0] word_t;

	logic                   CLOCK_50;
	logic                   arst_n_i;
	logic                   run_i;
	logic [`DRUM_ROW_W-1:0] rows_i;
	word_t                  incr_i;
	logic [3:0]             rho_shift_i;
	logic                   audio_ack_i;
	word_t                  sample_o;
	logic                   sample_valid_o;
	logic [31:0]            step_cycles_o;

	logic [31:0] case_words [0:6*MAX_CASES-1];
	word_t       cur_m  [`DRUM_COLS][`DRUM_MAX_ROWS];
	word_t       prev_m [`DRUM_COLS][`DRUM_MAX_ROWS];
	word_t       next_m [`DRUM_COLS][`DRUM_MAX_ROWS];
	word_t       rho_m;
	word_t       exp_sample;
	integer      seed;
	int          check_cnt;
	int          err_cnt;
	logic        timed_out;

	drum_synth_top uut (
		.CLOCK_50       (CLOCK_50),
		.arst_n_i       (arst_n_i),
		.run_i          (run_i),
		.rows_i         (rows_i),
		.incr_i         (incr_i),
		.rho_shift_i    (rho_shift_i),
		.audio_ack_i    (audio_ack_i),
		.sample_o       (sample_o),
		.sample_valid_o (sample_valid_o),
		.step_cycles_o  (step_cycles_o)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #20 CLOCK_50 = ~CLOCK_50;
	end

	////////////////////////////////////////
	// Reference grid model
	////////////////////////////////////////

	// Sign bit and bits 33 to 17 of the full product
	function automatic word_t q17_mul(input word_t a, input word_t b);
		longint full;
		full = longint'(a) * longint'(b);
		return {full[35], full[33:17]};
	endfunction

	function automatic word_t pyramid(input int col, input int row, input int rows,
			input word_t incr);
		int edge_d;
		int row_d;
		int lvl;
		edge_d = (col < `DRUM_COLS - 1 - col) ? col : `DRUM_COLS - 1 - col;
		row_d  = (row < rows - 1 - row) ? row : rows - 1 - row;
		lvl    = ((edge_d < row_d) ? edge_d : row_d) + 1;
		return word_t'(lvl * int'(incr));
	endfunction

	// Leapfrog step with all sums wrapping at the sample width
	function automatic word_t node_next(input word_t u, input int nb, input word_t pv,
			input word_t rho);
		word_t lap;
		word_t und;
		lap = word_t'(nb - 4 * int'(u));
		und = word_t'(int'(q17_mul(lap, rho)) + 2 * int'(u) - int'(pv) +
			(int'(pv) >>> `DRUM_DAMP_SHIFT));
		return word_t'(int'(und) - (int'(und) >>> `DRUM_DAMP_SHIFT));
	endfunction

	task automatic model_init(input int rows, input word_t incr);
		for (int c = 0; c < `DRUM_COLS; c++) begin
			for (int r = 0; r < rows; r++) begin
				cur_m[c][r]  = pyramid(c, r, rows, incr);
				prev_m[c][r] = cur_m[c][r];
			end
		end
		rho_m = `DRUM_RHO_0;
	endtask

	// Sample is the centre value before the update
	task automatic model_step(input int rows, input int shift);
		word_t tap;
		word_t sq;
		int    nb;
		int    rho_sum;
		tap = cur_m[`DRUM_TAP_COL][rows >> 1];
		for (int c = 0; c < `DRUM_COLS; c++) begin
			for (int r = 0; r < rows; r++) begin
				nb = 0;
				if (c > 0) begin
					nb += int'(cur_m[c-1][r]);
				end
				if (c < `DRUM_COLS - 1) begin
					nb += int'(cur_m[c+1][r]);
				end
				if (r > 0) begin
					nb += int'(cur_m[c][r-1]);
				end
				if (r < rows - 1) begin
					nb += int'(cur_m[c][r+1]);
				end
				next_m[c][r] = node_next(cur_m[c][r], nb, prev_m[c][r], rho_m);
			end
		end
		for (int c = 0; c < `DRUM_COLS; c++) begin
			for (int r = 0; r < rows; r++) begin
				prev_m[c][r] = cur_m[c][r];
				cur_m[c][r]  = next_m[c][r];
			end
		end
		exp_sample = tap;
		// Tension for the following step
		sq      = q17_mul(tap >>> shift, tap >>> shift);
		rho_sum = int'(`DRUM_RHO_0) + int'(sq);
		rho_m   = (rho_sum < int'(`DRUM_RHO_MAX)) ? word_t'(rho_sum) : `DRUM_RHO_MAX;
	endtask

	////////////////////////////////////////
	// Checks and handshake
	////////////////////////////////////////

	task automatic check_equal(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic wait_valid(input logic level);
		int n;
		n = 0;
		while (sample_valid_o !== level && n < WAIT_LIMIT) begin
			@(negedge CLOCK_50);
			n++;
		end
		if (sample_valid_o !== level) begin
			timed_out = 1'b1;
			$display("Timeout: sample_valid_o did not become %0b within %0d cycles",
				level, WAIT_LIMIT);
		end
	endtask

	task automatic hold_and_ack(input int max_delay);
		int    delay;
		word_t held;
		held  = sample_o;
		delay = $random(seed) % (max_delay + 1);
		if (delay < 0) begin
			delay = -delay;
		end
		// Back-pressure
		repeat (delay) begin
			@(negedge CLOCK_50);
			check_equal("valid while held", 32'(sample_valid_o), 32'd1);
			check_equal("sample while held", 32'(sample_o), 32'(held));
		end
		@(posedge CLOCK_50);
		audio_ack_i <= 1'b1;
		@(posedge CLOCK_50);
		audio_ack_i <= 1'b0;
		@(negedge CLOCK_50);
	endtask

	task automatic run_case(input int idx);
		int          rows;
		int          shift;
		int          steps;
		int          max_delay;
		int          errs_before;
		word_t       incr;
		logic [31:0] exp_cycles;
		rows        = int'(case_words[6*idx]);
		incr        = word_t'(case_words[6*idx+1]);
		shift       = int'(case_words[6*idx+2]);
		steps       = int'(case_words[6*idx+3]);
		max_delay   = int'(case_words[6*idx+4]);
		exp_cycles  = case_words[6*idx+5];
		errs_before = err_cnt;
		// Stop the core and restart it from the pyramid
		@(posedge CLOCK_50);
		run_i       <= 1'b0;
		audio_ack_i <= 1'b0;
		rows_i      <= case_words[6*idx][`DRUM_ROW_W-1:0];
		incr_i      <= incr;
		rho_shift_i <= case_words[6*idx+2][3:0];
		repeat (2) @(posedge CLOCK_50);
		run_i <= 1'b1;
		@(negedge CLOCK_50);
		model_init(rows, incr);
		for (int s = 0; s < steps && !timed_out; s++) begin
			wait_valid(1'b1);
			if (!timed_out) begin
				model_step(rows, shift);
				check_equal("sample", 32'(sample_o), 32'(exp_sample));
				check_equal("step cycles", step_cycles_o, exp_cycles);
				if (s < steps - 1) begin
					hold_and_ack(max_delay);
					wait_valid(1'b0);
				end
			end
		end
		$display("Case %0d: %0d rows, %0d steps, %0d errors",
			idx, rows, steps, err_cnt - errs_before);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		seed        = 98924;
		check_cnt   = 0;
		err_cnt     = 0;
		timed_out   = 1'b0;
		arst_n_i    = 1'b0;
		run_i       = 1'b0;
		rows_i      = '0;
		incr_i      = '0;
		rho_shift_i = '0;
		audio_ack_i = 1'b0;
		for (int i = 0; i < 6 * MAX_CASES; i++) begin
			case_words[i] = '0;
		end
		$readmemh("bench/drum_cases.txt", case_words);
		repeat (5) @(posedge CLOCK_50);
		arst_n_i <= 1'b1;
		@(negedge CLOCK_50);
		check_equal("valid after reset", 32'(sample_valid_o), 32'd0);
		check_equal("step cycles after reset", step_cycles_o, 32'd0);
		$display("Reset: %0d errors", err_cnt);
		for (int i = 0; i < MAX_CASES && !timed_out; i++) begin
			// Zero rows marks an unused slot
			if (case_words[6*i] != '0) begin
				run_case(i);
			end
		end
		$display("Totals: %0d checks, %0d errors", check_cnt, err_cnt);
		if (err_cnt == 0 && !timed_out) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* bench/drum_cases.txt */
// rows incr rho_shift steps max_ack_delay step_cycles, all fields in hex
// step_cycles is four cycles per row, a zero row count marks an unused slot
001 04000 2 4 0 00000004
006 00000 4 3 0 00000018
009 02000 3 6 2 00000024
008 06000 0 5 1 00000020
005 03000 1 4 c 00000014
00c 04000 2 5 3 00000030
002 05000 1 4 2 00000008
007 01800 0 3 5 0000001c

/* compile.f */
+incdir+include
design/drum_pkg.sv
design/column_ram.sv
design/node_update.sv
design/drum_column.sv
design/drum_sequencer.sv
design/step_timer.sv
design/tension_update.sv
design/drum_synth_top.sv
bench/drum_synth_asserts.sv
bench/drum_synth_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -f compile.f --top-module drum_synth_tb -o drum_sim &&
	./obj_dir/drum_sim | tee /dev/stderr | grep -q "^Simulation passed$" &&
	echo "run_sim: PASS" ||
	{ echo "run_sim: FAIL"; exit 1; }
